//--- design/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath
`define XLEN      32     // register and port width
`define NREGS     16     // general registers, x0 reads zero

// program memory
`define ROM_DEPTH 64     // instruction words
`define ROM_AW    6      // log2 of ROM_DEPTH

// uart receiver
`define BAUD_DIV  16     // clocks per bit on the line

// sequencer
`define RESET_PC  0      // first fetch address after rst

`endif

//--- design/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

  // 4-bit opcodes, anything not listed runs as a no-op
  typedef enum logic [3:0] {
    op_addi = 4'h0,
    op_jr   = 4'h3,
    op_in   = 4'h6,
    op_out  = 4'h7,
    op_intr = 4'h8,
    op_iret = 4'h9,
    op_halt = 4'ha
  } opcode_e;

  // instruction word, msb first
  typedef struct packed {
    logic [11:0] imm;
    logic [3:0]  rs2;
    logic [3:0]  rs1;
    logic [3:0]  rd;
    logic [3:0]  opt;    // reserved, not decoded
    opcode_e     opcode;
  } instr_t;

  typedef enum logic [1:0] {
    st_fetch,
    st_exec,
    st_halted            // left only by rst
  } cpu_state_e;

  // interrupt control register index, taken from rs1 of intr
  typedef enum logic [1:0] {
    intr_ack    = 2'd0,
    intr_enable = 2'd1,
    intr_vector = 2'd2
  } intr_reg_e;

  typedef struct packed {
    logic       valid;   // one-cycle strobe per frame
    logic [7:0] data;
  } rx_byte_t;

  typedef struct packed {
    logic             valid; // one-cycle strobe per out instruction
    logic [`XLEN-1:0] data;
  } out_t;

  typedef struct packed {
    logic              we;
    logic [`ROM_AW-1:0] addr;
    instr_t            data;
  } rom_wr_t;

endpackage

//--- design/uart_rx.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module uart_rx (
  input  logic              clk,
  input  logic              rst,
  input  logic              line,
  output cpu_pkg::rx_byte_t rx
);

  localparam int unsigned CW = $clog2(`BAUD_DIV);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_e;

  rx_state_e   state;
  logic        line_m;          // first sync stage
  logic        line_s;          // synchronized line
  logic [CW-1:0] cnt;           // clocks within the current bit
  logic [2:0]  bit_idx;
  logic [7:0]  shreg;

  // two-flop synchronizer, idles high
  always_ff @(posedge clk) begin
    if (rst) begin
      line_m <= 1'b1;
      line_s <= 1'b1;
    end else begin
      line_m <= line;
      line_s <= line_m;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= rx_idle;
      cnt      <= '0;
      bit_idx  <= '0;
      rx.valid <= 1'b0;
    end else begin
      rx.valid <= 1'b0;
      cnt      <= cnt + 1'b1;
      case (state)
        rx_idle: begin
          cnt <= '0;
          if (!line_s) state <= rx_start;          // falling start edge
        end
        rx_start: begin
          if (cnt == CW'(`BAUD_DIV / 2 - 1)) begin // half bit, confirm start
            cnt     <= '0;
            bit_idx <= '0;
            state   <= line_s ? rx_idle : rx_data;
          end
        end
        rx_data: begin
          if (cnt == CW'(`BAUD_DIV - 1)) begin     // bit center
            cnt   <= '0;
            shreg <= {line_s, shreg[7:1]};         // lsb arrives first
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= rx_stop;
          end
        end
        rx_stop: begin
          if (cnt == CW'(`BAUD_DIV - 1)) begin
            state <= rx_idle;
            if (line_s) begin                      // low stop bit drops the frame
              rx.valid <= 1'b1;
              rx.data  <= shreg;
            end
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  logic [3:0]       rs1_addr,
  input  logic [3:0]       rs2_addr,
  output logic [`XLEN-1:0] rs1_data,
  output logic [`XLEN-1:0] rs2_data,
  input  logic             we,
  input  logic [3:0]       rd_addr,
  input  logic [`XLEN-1:0] rd_data
);

  logic [`XLEN-1:0] regs [`NREGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NREGS; i++) regs[i] <= '0;  // programs start from zeros
    end else if (we && rd_addr != 4'd0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == 4'd0) ? '0 : regs[rs1_addr]; // x0 is hardwired zero
  assign rs2_data = (rs2_addr == 4'd0) ? '0 : regs[rs2_addr];

endmodule

//--- design/intr_ctrl.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module intr_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               rx_strobe,
  input  logic               wr_en,
  input  cpu_pkg::intr_reg_e wr_reg,
  input  logic [`XLEN-1:0]   wr_value,
  input  logic               iret,
  input  logic [`ROM_AW-1:0] cur_pc,
  input  logic               trap_ack,
  output logic               take_trap,
  output logic [`ROM_AW-1:0] vector,
  output logic [`ROM_AW-1:0] epc
);

  logic irr;              // interrupt request from the uart
  logic enable;
  logic in_handler;
  logic ack_clear;

  assign ack_clear = wr_en && (wr_reg == cpu_pkg::intr_ack) && (wr_value == `XLEN'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      irr <= 1'b0;
    end else if (rx_strobe) begin
      irr <= 1'b1;          // a new byte beats a same-cycle ack
    end else if (ack_clear) begin
      irr <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      enable <= 1'b0;
      vector <= '0;
    end else if (wr_en) begin
      case (wr_reg)
        cpu_pkg::intr_enable: enable <= wr_value[0];
        cpu_pkg::intr_vector: vector <= wr_value[`ROM_AW-1:0];
        default: ;          // ack is handled with irr
      endcase
    end
  end

  // trap entry and return, no nesting
  always_ff @(posedge clk) begin
    if (rst) begin
      in_handler <= 1'b0;
    end else if (trap_ack) begin
      in_handler <= 1'b1;
    end else if (iret) begin
      in_handler <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (trap_ack) epc <= cur_pc;  // instruction that was about to be fetched
  end

  // pending irr re-traps right after iret unless acked
  assign take_trap = irr && enable && !in_handler;

endmodule

//--- design/prog_rom.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module prog_rom (
  input  logic               clk,
  input  cpu_pkg::rom_wr_t   load,
  input  logic [`ROM_AW-1:0] addr,
  output cpu_pkg::instr_t    instr
);

  cpu_pkg::instr_t mem [`ROM_DEPTH];

  always_ff @(posedge clk) begin
    if (load.we) mem[load.addr] <= load.data;  // loaded while the board is in reset
  end

  always_ff @(posedge clk) begin
    instr <= mem[addr];                        // one cycle read latency
  end

endmodule

//--- design/cpu.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module cpu (
  input  logic               clk,
  input  logic               rst,
  output logic [`ROM_AW-1:0] rom_addr,
  input  cpu_pkg::instr_t    instr,
  input  cpu_pkg::rx_byte_t  rx,
  output cpu_pkg::out_t      out,
  output logic               halted
);

  cpu_pkg::cpu_state_e state;
  logic [`ROM_AW-1:0]  pc;
  logic [7:0]          last_byte;   // most recent uart byte, read by in from port 1

  logic [`XLEN-1:0]    rs1_data;
  logic [`XLEN-1:0]    rs2_data;
  logic [`XLEN-1:0]    imm_ext;
  logic [`XLEN-1:0]    io_data;
  logic                rd_we;
  logic [`XLEN-1:0]    rd_data;

  logic                exec;
  logic                take_trap;
  logic                trap_ack;
  logic [`ROM_AW-1:0]  vector;
  logic [`ROM_AW-1:0]  epc;
  logic                intr_wr;
  cpu_pkg::intr_reg_e  intr_reg;
  logic                iret;

  assign exec     = (state == cpu_pkg::st_exec);
  assign halted   = (state == cpu_pkg::st_halted);
  assign trap_ack = (state == cpu_pkg::st_fetch) && take_trap;

  // a trap fetches straight from the vector
  assign rom_addr = trap_ack ? vector : pc;

  assign imm_ext = {{(`XLEN - 12){instr.imm[11]}}, instr.imm};  // sign extended
  assign io_data = (rs1_data == `XLEN'(1)) ? {{(`XLEN - 8){1'b0}}, last_byte} : '0;

  // execute decode, only meaningful in the exec cycle
  always_comb begin
    rd_we    = 1'b0;
    rd_data  = rs1_data + imm_ext;
    intr_wr  = 1'b0;
    intr_reg = cpu_pkg::intr_reg_e'(rs1_data[1:0]);
    iret     = 1'b0;
    if (exec) begin
      case (instr.opcode)
        cpu_pkg::op_addi: rd_we = 1'b1;
        cpu_pkg::op_in: begin
          rd_we   = 1'b1;
          rd_data = io_data;
        end
        cpu_pkg::op_intr: intr_wr = (rs1_data < `XLEN'(3));  // unknown index is ignored
        cpu_pkg::op_iret: iret = 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cpu_pkg::st_fetch;
      pc    <= `ROM_AW'(`RESET_PC);
    end else begin
      case (state)
        cpu_pkg::st_fetch: begin
          pc    <= rom_addr;        // old pc already saved by intr_ctrl on a trap
          state <= cpu_pkg::st_exec;
        end
        cpu_pkg::st_exec: begin
          state <= cpu_pkg::st_fetch;
          case (instr.opcode)
            cpu_pkg::op_jr:   pc <= rs1_data[`ROM_AW-1:0];
            cpu_pkg::op_iret: pc <= epc;
            cpu_pkg::op_halt: state <= cpu_pkg::st_halted;
            default:          pc <= pc + 1'b1;
          endcase
        end
        default: state <= cpu_pkg::st_halted;  // halted holds until rst
      endcase
    end
  end

  // output port strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= exec && (instr.opcode == cpu_pkg::op_out);
      if (exec && instr.opcode == cpu_pkg::op_out) out.data <= rs2_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_byte <= '0;
    end else if (rx.valid) begin
      last_byte <= rx.data;     // later bytes overwrite, no back-pressure
    end
  end

  reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (instr.rs1),
    .rs2_addr (instr.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rd_we),
    .rd_addr  (instr.rd),
    .rd_data  (rd_data)
  );

  intr_ctrl i_intr_ctrl (
    .clk       (clk),
    .rst       (rst),
    .rx_strobe (rx.valid),
    .wr_en     (intr_wr),
    .wr_reg    (intr_reg),
    .wr_value  (rs2_data),
    .iret      (iret),
    .cur_pc    (pc),
    .trap_ack  (trap_ack),
    .take_trap (take_trap),
    .vector    (vector),
    .epc       (epc)
  );

endmodule

//--- design/mother_board.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module mother_board (
  input  logic             clk,
  input  logic             rst,
  input  logic             uart_rx,   // serial line, idles high
  input  cpu_pkg::rom_wr_t rom_load,  // only used while rst is high
  output cpu_pkg::out_t    out,
  output logic             halted
);

  logic [`ROM_AW-1:0] rom_addr;
  cpu_pkg::instr_t    instr;
  cpu_pkg::rx_byte_t  rx;

  prog_rom i_prog_rom (
    .clk   (clk),
    .load  (rom_load),
    .addr  (rom_addr),
    .instr (instr)
  );

  cpu i_cpu (
    .clk      (clk),
    .rst      (rst),
    .rom_addr (rom_addr),
    .instr    (instr),
    .rx       (rx),
    .out      (out),
    .halted   (halted)
  );

  uart_rx i_uart_rx (
    .clk  (clk),
    .rst  (rst),
    .line (uart_rx),
    .rx   (rx)
  );

endmodule

//--- dv/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// works on prog and exp_q of the including testbench

function automatic cpu_pkg::instr_t encode_instr(input cpu_pkg::opcode_e op,
    input logic [3:0] rd, input logic [3:0] rs1, input logic [3:0] rs2, input logic [11:0] imm);
  return '{imm: imm, rs2: rs2, rs1: rs1, rd: rd, opt: 4'h0, opcode: op};
endfunction

task automatic clear_program();
  for (int a = 0; a < `ROM_DEPTH; a++)
    prog[a] = encode_instr(cpu_pkg::op_addi, 4'd0, 4'd0, 4'd0, 12'(a));  // no-op tagged by address
endtask

task automatic build_out_program();
  clear_program();
  prog[0]  = encode_instr(cpu_pkg::op_addi, 4'd1, 4'd0, 4'd0, 12'd5);
  prog[1]  = encode_instr(cpu_pkg::op_out,  4'd0, 4'd0, 4'd1, 12'd0);
  prog[2]  = encode_instr(cpu_pkg::op_addi, 4'd2, 4'd1, 4'd0, 12'hffd);  // negative immediate
  prog[3]  = encode_instr(cpu_pkg::op_out,  4'd0, 4'd0, 4'd2, 12'd0);
  prog[4]  = encode_instr(cpu_pkg::op_addi, 4'd3, 4'd2, 4'd0, 12'h7ff);
  prog[5]  = encode_instr(cpu_pkg::opcode_e'(4'hc), 4'd3, 4'd3, 4'd3, 12'hfff);  // no-op
  prog[6]  = encode_instr(cpu_pkg::op_out,  4'd0, 4'd0, 4'd3, 12'd0);
  prog[7]  = encode_instr(cpu_pkg::op_addi, 4'd0, 4'd0, 4'd0, 12'd9);    // x0 stays zero
  prog[8]  = encode_instr(cpu_pkg::op_out,  4'd0, 4'd0, 4'd0, 12'd0);
  prog[9]  = encode_instr(cpu_pkg::op_addi, 4'd4, 4'd0, 4'd0, 12'd12);
  prog[10] = encode_instr(cpu_pkg::op_jr,   4'd0, 4'd4, 4'd0, 12'd0);
  prog[11] = encode_instr(cpu_pkg::op_out,  4'd0, 4'd0, 4'd1, 12'd0);    // skipped by jr
  prog[12] = encode_instr(cpu_pkg::op_out,  4'd0, 4'd0, 4'd4, 12'd0);
  prog[13] = encode_instr(cpu_pkg::op_halt, 4'd0, 4'd0, 4'd0, 12'd0);
endtask

// main code spins on jr r5 at 7 until the handler at 20 points r5 at the markers
// with the enable off it runs the no-op slide from 31, then 29 and 27, before the markers
task automatic build_irq_program(input bit enable, input bit ack);
  clear_program();
  prog[0]  = encode_instr(cpu_pkg::op_addi, 4'd1, 4'd0, 4'd0, 12'd1);   // enable index, uart port
  prog[1]  = encode_instr(cpu_pkg::op_addi, 4'd2, 4'd0, 4'd0, 12'd2);   // vector index
  prog[2]  = encode_instr(cpu_pkg::op_addi, 4'd3, 4'd0, 4'd0, 12'd20);  // handler address
  prog[3]  = encode_instr(cpu_pkg::op_addi, 4'd4, 4'd0, 4'd0, {11'd0, enable});
  prog[4]  = encode_instr(cpu_pkg::op_addi, 4'd5, 4'd0, 4'd0, enable ? 12'd7 : 12'd31);
  prog[5]  = encode_instr(cpu_pkg::op_intr, 4'd0, 4'd2, 4'd3, 12'd0);
  prog[6]  = encode_instr(cpu_pkg::op_intr, 4'd0, 4'd1, 4'd4, 12'd0);
  prog[7]  = encode_instr(cpu_pkg::op_jr,   4'd0, 4'd5, 4'd0, 12'd0);
  prog[8]  = encode_instr(cpu_pkg::op_addi, 4'd7, 4'd0, 4'd0, 12'h011);  // main markers
  prog[9]  = encode_instr(cpu_pkg::op_out,  4'd0, 4'd0, 4'd7, 12'd0);
  prog[10] = encode_instr(cpu_pkg::op_addi, 4'd7, 4'd0, 4'd0, 12'h022);
  prog[11] = encode_instr(cpu_pkg::op_out,  4'd0, 4'd0, 4'd7, 12'd0);
  prog[12] = encode_instr(cpu_pkg::op_halt, 4'd0, 4'd0, 4'd0, 12'd0);
  prog[20] = encode_instr(cpu_pkg::op_in,   4'd6, 4'd1, 4'd0, 12'd0);
  prog[21] = encode_instr(cpu_pkg::op_out,  4'd0, 4'd0, 4'd6, 12'd0);
  if (ack) prog[22] = encode_instr(cpu_pkg::op_intr, 4'd0, 4'd0, 4'd1, 12'd0);
  prog[23] = encode_instr(cpu_pkg::op_addi, 4'd5, 4'd0, 4'd0, 12'd8);
  prog[24] = encode_instr(cpu_pkg::op_iret, 4'd0, 4'd0, 4'd0, 12'd0);
  prog[25] = encode_instr(cpu_pkg::op_addi, 4'd10, 4'd0, 4'd0, 12'd8);  // slide exit
  prog[26] = encode_instr(cpu_pkg::op_jr,   4'd0, 4'd10, 4'd0, 12'd0);
  prog[61] = encode_instr(cpu_pkg::op_addi, 4'd8, 4'd8, 4'd0, 12'hffe);  // two back per pass
  prog[62] = encode_instr(cpu_pkg::op_addi, 4'd9, 4'd8, 4'd0, 12'd31);
  prog[63] = encode_instr(cpu_pkg::op_jr,   4'd0, 4'd9, 4'd0, 12'd0);
endtask

// irr starts set when the byte arrived before the first fetch
function automatic bit model_run(input bit arrived, input logic [7:0] rx_byte, input int max_out);
  logic [`XLEN-1:0]   regs [`NREGS];
  logic [`XLEN-1:0]   a;
  logic [`XLEN-1:0]   b;
  logic [`ROM_AW-1:0] pc;
  logic [`ROM_AW-1:0] epc;
  logic [`ROM_AW-1:0] vec;
  bit                 irr;
  bit                 en;
  bit                 in_handler;
  cpu_pkg::instr_t    ins;
  for (int r = 0; r < `NREGS; r++) regs[r] = '0;
  exp_q.delete();
  pc = `ROM_AW'(`RESET_PC);
  epc = '0;
  vec = '0;
  irr = arrived;
  en = 1'b0;
  in_handler = 1'b0;
  for (int step = 0; step < 4000; step++) begin
    if (irr && en && !in_handler) begin  // the trap takes this fetch
      epc = pc;
      pc = vec;
      in_handler = 1'b1;
    end
    ins = prog[pc];
    a = regs[ins.rs1];
    b = regs[ins.rs2];
    pc = pc + 1'b1;
    case (ins.opcode)
      cpu_pkg::op_addi: regs[ins.rd] = a + {{(`XLEN - 12){ins.imm[11]}}, ins.imm};
      cpu_pkg::op_jr:   pc = a[`ROM_AW-1:0];
      cpu_pkg::op_in:   regs[ins.rd] = (a == 1 && arrived) ? `XLEN'(rx_byte) : '0;
      cpu_pkg::op_out: begin
        exp_q.push_back(b);
        if (exp_q.size() >= max_out) return 1'b0;
      end
      cpu_pkg::op_intr: begin
        if (a == 0 && b == 1) irr = 1'b0;
        else if (a == 1) en = b[0];
        else if (a == 2) vec = b[`ROM_AW-1:0];
      end
      cpu_pkg::op_iret: begin
        pc = epc;
        in_handler = 1'b0;
      end
      cpu_pkg::op_halt: return 1'b1;
      default: ;
    endcase
    regs[0] = '0;
  end
  return 1'b0;
endfunction

`endif

//--- dv/tb_mother_board.sv
`timescale 1ns/1ns
`include "cpu_params.svh"

module tb_mother_board;

  logic             clk;
  logic             rst;
  logic             uart_line;
  cpu_pkg::rom_wr_t rom_load;
  cpu_pkg::out_t    out;
  logic             halted;

  cpu_pkg::instr_t  prog [`ROM_DEPTH];
  logic [`XLEN-1:0] exp_q [$];   // model outputs
  cpu_pkg::out_t    got_q [$];   // captured strobes
  logic             rst_prev;    // rst as seen by the last rising edge
  integer           seed;

  `include "tb_programs.svh"

  mother_board i_mother_board (
    .clk      (clk),
    .rst      (rst),
    .uart_rx  (uart_line),
    .rom_load (rom_load),
    .out      (out),
    .halted   (halted)
  );

  always #5 clk = ~clk;

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_out(input cpu_pkg::out_t got, input logic [`XLEN-1:0] exp,
                           input string what);
    if (got.data !== exp)
      stop_on_error($sformatf("Mismatch at %0t: %s got %h expected %h",
                              $time, what, got.data, exp));
  endtask

  task automatic check_halted(input logic got, input logic exp, input string what);
    if (got !== exp)
      stop_on_error($sformatf("Mismatch at %0t: %s halted is %b expected %b",
                              $time, what, got, exp));
  endtask

  // strobes sampled at the falling edge
  always @(negedge clk) begin
    if (out.valid === 1'b1 && rst_prev) stop_on_error("Output strobe seen while rst was high");
    else if (out.valid === 1'b1) got_q.push_back(out);
    rst_prev = rst;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic reset_and_load();
    next_cycle();
    rst = 1'b1;
    for (int a = 0; a < `ROM_DEPTH; a++) begin
      rom_load.we   = 1'b1;
      rom_load.addr = `ROM_AW'(a);
      rom_load.data = prog[a];
      next_cycle();
    end
    rom_load = '0;
    repeat (8) next_cycle();
    got_q.delete();
    rst = 1'b0;
  endtask

  task automatic send_uart_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};  // stop, data lsb first, start
    for (int i = 0; i < 10; i++) begin
      uart_line = frame[i];
      repeat (`BAUD_DIV) next_cycle();
    end
  endtask

  task automatic wait_for_outputs(input int n, input int limit);
    int cycles;
    cycles = 0;
    while (got_q.size() < n) begin
      if (cycles >= limit)
        stop_on_error($sformatf("Timeout: only %0d of %0d outputs seen", got_q.size(), n));
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic wait_halt_window(input int limit);
    int cycles;
    cycles = 0;
    while (halted !== 1'b1 && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic run_program(input string what, input bit send, input logic [7:0] b);
    bit exp_halt;
    exp_halt = model_run(send, b, 16);
    reset_and_load();
    if (send) send_uart_byte(b);
    wait_halt_window(2000);
    check_halted(halted, exp_halt, what);
    if (got_q.size() != exp_q.size())
      stop_on_error($sformatf("Mismatch at %0t: %s gave %0d outputs, expected %0d",
                              $time, what, got_q.size(), exp_q.size()));
    foreach (exp_q[i]) check_out(got_q[i], exp_q[i], $sformatf("%s output %0d", what, i));
  endtask

  initial begin : main_seq
    logic [31:0] rnd;
    bit          exp_halt;
    clk       = 1'b0;
    rst       = 1'b1;
    uart_line = 1'b1;
    rom_load  = '0;
    rst_prev  = 1'b1;
    seed      = 32'hfe27_a9b3;

    build_out_program();
    run_program("addi and out", 1'b0, 8'h00);

    build_irq_program(1'b1, 1'b1);
    run_program("handler with ack", 1'b1, 8'h8f);

    // irr is never cleared so the handler re-enters after every iret
    build_irq_program(1'b1, 1'b0);
    exp_halt = model_run(1'b1, 8'h8f, 3);
    reset_and_load();
    send_uart_byte(8'h8f);
    wait_for_outputs(3, 400);
    for (int i = 0; i < 3; i++) check_out(got_q[i], exp_q[i], "handler without ack");
    for (int c = 0; c < 300; c++) begin
      @(negedge clk);
      check_halted(halted, exp_halt, "handler without ack");
    end
    foreach (got_q[i]) check_out(got_q[i], exp_q[0], "no main marker");

    build_irq_program(1'b0, 1'b1);
    run_program("enable off", 1'b1, 8'h8f);

    build_irq_program(1'b1, 1'b1);
    for (int n = 0; n < 10; n++) begin
      rnd = $random(seed);
      run_program($sformatf("random byte %h", rnd[7:0]), 1'b1, rnd[7:0]);
      check_out(got_q[0], `XLEN'(rnd[7:0]), "handler echo");
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- files.f
+incdir+design
+incdir+dv
design/cpu_pkg.sv
design/uart_rx.sv
design/reg_file.sv
design/intr_ctrl.sv
design/prog_rom.sv
design/cpu.sv
design/mother_board.sv
dv/tb_mother_board.sv
